/* rtl/rob_consts.svh */
// reorder buffer constants
// buffer depth, physical register count and the index widths

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// entries in the buffer
// a power of two lets the pointers wrap on their own
`define ROB_DEPTH 16
`define ROB_IDX_W 4

// physical register file
`define NUM_PR    64
`define PR_IDX_W  6

// freed-entry count wide enough to hold ROB_DEPTH
`define CREDIT_W  5

`endif

/* rtl/rob_pkg.sv */
// reorder buffer package
// index types and the packed structs passed between the buffer blocks

`include "rob_consts.svh"

package rob_pkg;

  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`PR_IDX_W-1:0]  preg_t;
  typedef logic [`CREDIT_W-1:0]  credit_t;

  // renamed instruction from the dispatcher
  typedef struct packed {
    logic  valid;
    preg_t t;
    preg_t t_old;
  } dispatch_t;

  // execution side reports an entry finished
  typedef struct packed {
    logic     valid;
    rob_idx_t rob_idx;
  } complete_t;

  // branch mispredict that squashes everything younger than branch_idx
  typedef struct packed {
    logic     valid;
    rob_idx_t branch_idx;
  } flush_t;

  // state held by one buffer slot
  typedef struct packed {
    logic  valid;
    logic  complete;
    preg_t t;
    preg_t t_old;
  } entry_t;

  // retiring instruction whose t_old goes back to the free list
  typedef struct packed {
    logic  valid;
    preg_t t;
    preg_t t_old;
  } retire_t;

endpackage

/* rtl/rob_alloc.sv */
// reorder buffer allocator
// owns the tail pointer, picks the entry a dispatch writes and
// builds the squash mask and count on a branch mispredict

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_alloc (
  input  logic                                clock,
  input  logic                                reset,
  input  rob_pkg::dispatch_t                  dispatch,
  input  rob_pkg::flush_t                     flush,
  input  rob_pkg::entry_t [`ROB_DEPTH-1:0]    entries,
  output rob_pkg::rob_idx_t                   disp_idx,
  output logic [`ROB_DEPTH-1:0]               write_en,
  output rob_pkg::dispatch_t                  write_data,
  output logic [`ROB_DEPTH-1:0]               squash_mask,
  output rob_pkg::credit_t                    squash_count
);

  import rob_pkg::*;

  rob_idx_t tail;
  rob_idx_t tail_next;
  logic     flush_taken;
  logic     disp_accept;
  logic     branch_at_or_after_tail;

  // a flush only counts if the branch is still in the buffer
  assign flush_taken = flush.valid && entries[flush.branch_idx].valid;

  // dispatch in the same cycle as a taken flush is dropped
  assign disp_accept = dispatch.valid && !flush_taken;

  assign disp_idx   = tail;
  assign write_data = dispatch;

  always_comb begin
    write_en = '0;
    if (disp_accept) begin
      write_en[tail] = 1'b1;
    end
  end

  // branch index at or above the tail means the live range wraps
  assign branch_at_or_after_tail = flush.branch_idx >= tail;

  // entries strictly younger than the branch, up to the tail
  always_comb begin
    squash_mask = '0;
    if (flush_taken) begin
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        if (branch_at_or_after_tail) begin
          // wrapped range below the tail or above the branch
          squash_mask[i] = (i < int'(tail)) || (i > int'(flush.branch_idx));
        end else begin
          squash_mask[i] = (i < int'(tail)) && (i > int'(flush.branch_idx));
        end
      end
    end
  end

  // live entries thrown away count toward the credit return
  always_comb begin
    squash_count = '0;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      if (squash_mask[i] && entries[i].valid) begin
        squash_count = squash_count + credit_t'(1);
      end
    end
  end

  always_comb begin
    tail_next = tail;
    if (flush_taken) begin
      // restart right after the branch
      tail_next = flush.branch_idx + rob_idx_t'(1);
    end else if (disp_accept) begin
      tail_next = tail + rob_idx_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else begin
      tail <= tail_next;
    end
  end

endmodule

/* rtl/rob_entry.sv */
// reorder buffer entry
// one slot with valid, complete and the new and old register tags

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_entry #(
  parameter rob_pkg::rob_idx_t entry_idx = '0
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               write_en,
  input  rob_pkg::dispatch_t write_data,
  input  rob_pkg::complete_t complete,
  input  logic               squash,
  input  logic               free,
  output rob_pkg::entry_t    state
);

  import rob_pkg::*;

  logic  valid_q;
  logic  complete_q;
  preg_t t_q;
  preg_t t_old_q;
  logic  complete_hit;

  // only place where a completion index is matched
  assign complete_hit = complete.valid && (complete.rob_idx == entry_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q    <= 1'b0;
      complete_q <= 1'b0;
    end else if (write_en) begin
      valid_q    <= 1'b1;
      complete_q <= 1'b0;
    end else if (squash || free) begin
      valid_q    <= 1'b0;
      complete_q <= 1'b0;
    end else if (complete_hit && valid_q) begin
      complete_q <= 1'b1;
    end
  end

  // tags only change on a new dispatch
  always_ff @(posedge clock) begin
    if (write_en) begin
      t_q     <= write_data.t;
      t_old_q <= write_data.t_old;
    end
  end

  always_comb begin
    state.valid    = valid_q;
    state.complete = complete_q;
    state.t        = t_q;
    state.t_old    = t_old_q;
  end

endmodule

/* rtl/rob_retire.sv */
// reorder buffer retire unit
// owns the head pointer, retires the oldest entry once it is complete
// and returns freed entries to the dispatcher as registered credit

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_retire (
  input  logic                             clock,
  input  logic                             reset,
  input  rob_pkg::entry_t [`ROB_DEPTH-1:0] entries,
  input  rob_pkg::credit_t                 squash_count,
  output logic [`ROB_DEPTH-1:0]            free_head,
  output rob_pkg::retire_t                 retire,
  output rob_pkg::credit_t                 credit
);

  import rob_pkg::*;

  rob_idx_t head;
  entry_t   head_entry;
  logic     do_retire;
  credit_t  credit_next;

  assign head_entry = entries[head];

  // head retires once it is finished
  assign do_retire = head_entry.valid && head_entry.complete;

  always_comb begin
    retire.valid = do_retire;
    retire.t     = head_entry.t;
    retire.t_old = head_entry.t_old;
  end

  // clear the retiring slot at this edge
  always_comb begin
    free_head = '0;
    if (do_retire) begin
      free_head[head] = 1'b1;
    end
  end

  // retires plus squashes of this cycle
  always_comb begin
    credit_next = squash_count;
    if (do_retire) begin
      credit_next = squash_count + credit_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head   <= '0;
      credit <= '0;
    end else begin
      credit <= credit_next;
      if (do_retire) begin
        head <= head + rob_idx_t'(1);
      end
    end
  end

endmodule

/* rtl/rob_top.sv */
// reorder buffer top level
// allocator, a row of identical entry slots and the retire unit

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_top (
  input  logic               clock,
  input  logic               reset,
  input  rob_pkg::dispatch_t dispatch,
  input  rob_pkg::complete_t complete,
  input  rob_pkg::flush_t    flush,
  output rob_pkg::rob_idx_t  disp_idx,
  output rob_pkg::retire_t   retire,
  output rob_pkg::credit_t   credit
);

  import rob_pkg::*;

  logic [`ROB_DEPTH-1:0]   write_en;
  dispatch_t               write_data;
  logic [`ROB_DEPTH-1:0]   squash_mask;
  credit_t                 squash_count;
  logic [`ROB_DEPTH-1:0]   free_head;
  entry_t [`ROB_DEPTH-1:0] entries;

  rob_alloc u_rob_alloc (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (dispatch),
    .flush        (flush),
    .entries      (entries),
    .disp_idx     (disp_idx),
    .write_en     (write_en),
    .write_data   (write_data),
    .squash_mask  (squash_mask),
    .squash_count (squash_count)
  );

  // each slot knows its own index for completion matching
  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_entry
    rob_entry #(
      .entry_idx (rob_idx_t'(i))
    ) u_rob_entry (
      .clock      (clock),
      .reset      (reset),
      .write_en   (write_en[i]),
      .write_data (write_data),
      .complete   (complete),
      .squash     (squash_mask[i]),
      .free       (free_head[i]),
      .state      (entries[i])
    );
  end

  rob_retire u_rob_retire (
    .clock        (clock),
    .reset        (reset),
    .entries      (entries),
    .squash_count (squash_count),
    .free_head    (free_head),
    .retire       (retire),
    .credit       (credit)
  );

endmodule

/* dv/rob_checker.sv */
// reorder buffer checker
// keeps the expected retire queue and compares retire, credit and
// dispatch index against it every cycle

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_checker (
  input  logic               clock,
  input  logic               reset,
  input  rob_pkg::dispatch_t dispatch,
  input  rob_pkg::rob_idx_t  disp_idx,
  input  rob_pkg::complete_t complete,
  input  rob_pkg::flush_t    flush,
  input  rob_pkg::retire_t   retire,
  input  rob_pkg::credit_t   credit,
  input  rob_pkg::credit_t   squash_exp,
  input  logic               finished,
  output int                 value_errors,
  output int                 other_errors
);

  import rob_pkg::*;

  // an instruction waiting to retire
  typedef struct packed {
    rob_idx_t idx;
    preg_t    t;
    preg_t    t_old;
  } expect_t;

  expect_t               exp_q[$];
  logic [`ROB_DEPTH-1:0] done;
  rob_idx_t              exp_tail;
  credit_t               exp_credit;
  logic                  exp_retire;
  int                    credit_sum;
  int                    disp_count;
  int                    retired;
  int                    squashed;
  logic                  reported;

  // inputs and outputs are settled mid-cycle
  always @(negedge clock) begin
    expect_t e;
    if (reset) begin
      exp_q.delete();
      done         = '0;
      exp_tail     = '0;
      exp_credit   = '0;
      exp_retire   = 1'b0;
      credit_sum   = 0;
      disp_count   = 0;
      retired      = 0;
      squashed     = 0;
      value_errors = 0;
      other_errors = 0;
      reported     = 1'b0;
    end else begin
      if (credit !== exp_credit) begin
        $display("** Error at %0t: credit is %0d, expected %0d", $time, credit, exp_credit);
        value_errors++;
      end
      credit_sum += int'(credit);
      if (credit_sum > disp_count) begin
        $display("credit total %0d at %0t is more than the %0d dispatches made",
                 credit_sum, $time, disp_count);
        other_errors++;
      end
      // oldest instruction retires once its completion has been sampled
      exp_retire = (exp_q.size() > 0) && done[exp_q[0].idx];
      if (retire.valid !== exp_retire) begin
        $display("** Error at %0t: retire.valid is %0b, expected %0b",
                 $time, retire.valid, exp_retire);
        value_errors++;
      end
      if (exp_retire) begin
        e = exp_q.pop_front();
        retired++;
        if (retire.t !== e.t) begin
          $display("** Error at %0t: retire.t is %0d, expected %0d", $time, retire.t, e.t);
          value_errors++;
        end
        if (retire.t_old !== e.t_old) begin
          $display("** Error at %0t: retire.t_old is %0d, expected %0d",
                   $time, retire.t_old, e.t_old);
          value_errors++;
        end
      end
      if (flush.valid) begin
        // youngest go first
        for (int i = 0; i < int'(squash_exp); i++) begin
          if (exp_q.size() > 0) begin
            void'(exp_q.pop_back());
          end
        end
        squashed += int'(squash_exp);
        exp_tail = flush.branch_idx + rob_idx_t'(1);
      end
      if (complete.valid) begin
        done[complete.rob_idx] = 1'b1;
      end
      // a dispatch next to a flush is dropped
      if (dispatch.valid && !flush.valid) begin
        if (disp_idx !== exp_tail) begin
          $display("** Error at %0t: disp_idx is %0d, expected %0d", $time, disp_idx, exp_tail);
          value_errors++;
        end
        e.idx   = exp_tail;
        e.t     = dispatch.t;
        e.t_old = dispatch.t_old;
        exp_q.push_back(e);
        done[exp_tail] = 1'b0;
        exp_tail = exp_tail + rob_idx_t'(1);
        disp_count++;
      end
      exp_credit = credit_t'(exp_retire) + (flush.valid ? squash_exp : credit_t'(0));
      if (finished && !reported) begin
        reported = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d instructions never retired", exp_q.size());
          other_errors++;
        end
        if (credit_sum != retired + squashed) begin
          $display("** Error at %0t: credit total is %0d, expected %0d",
                   $time, credit_sum, retired + squashed);
          value_errors++;
        end
        $display("checker: %0d dispatched, %0d retired, %0d squashed",
                 disp_count, retired, squashed);
      end
    end
  end

endmodule

/* dv/rob_tb.sv */
// reorder buffer testbench
// plays the dispatcher and the execution side around the buffer,
// with the squash reference model and the end-of-run verdict

`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_tb;

  import rob_pkg::*;

  localparam int CYCLE_NS     = 20;
  localparam int RANDOM_OPS   = 1500;
  localparam int DIRECTED_OPS = 160;
  localparam int TOTAL_OPS    = RANDOM_OPS + DIRECTED_OPS;

  // an in-flight instruction as the dispatcher sees it
  typedef struct packed {
    rob_idx_t idx;
    logic     sent;
  } flight_t;

  logic      clock;
  logic      reset;
  dispatch_t dispatch;
  complete_t complete;
  flush_t    flush;
  rob_idx_t  disp_idx;
  retire_t   retire;
  credit_t   credit;
  credit_t   squash_exp;
  logic      finished;
  int        value_errors;
  int        other_errors;

  flight_t   inflight[$];
  int        credits;
  int        stall_errors;

  rob_top u_rob_top (
    .clock    (clock),
    .reset    (reset),
    .dispatch (dispatch),
    .complete (complete),
    .flush    (flush),
    .disp_idx (disp_idx),
    .retire   (retire),
    .credit   (credit)
  );

  rob_checker u_rob_checker (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (dispatch),
    .disp_idx     (disp_idx),
    .complete     (complete),
    .flush        (flush),
    .retire       (retire),
    .credit       (credit),
    .squash_exp   (squash_exp),
    .finished     (finished),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  initial begin
    clock = 1'b0;
    forever #(CYCLE_NS / 2) clock = ~clock;
  end

  initial begin
    #(TOTAL_OPS * 40 * CYCLE_NS);
    $display("watchdog expired after %0d cycles, run did not finish", TOTAL_OPS * 40);
    $display("Testbench failed");
    $finish;
  end

  function automatic preg_t random_tag();
    return preg_t'($urandom_range(0, `NUM_PR - 1));
  endfunction

  // list position of a buffer index or -1 when not in flight
  function automatic int position_of(input rob_idx_t idx);
    int pos;
    pos = -1;
    for (int i = 0; i < inflight.size(); i++) begin
      if (inflight[i].idx == idx) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  // reference model of a flush
  // everything dispatched after the branch is squashed
  function automatic int younger_count(input rob_idx_t branch);
    int pos;
    pos = position_of(branch);
    if (pos < 0) begin
      return 0;
    end
    return inflight.size() - 1 - pos;
  endfunction

  // random position whose completion is still unsent, or -1
  function automatic int pick_unsent();
    int cands[$];
    for (int i = 0; i < inflight.size(); i++) begin
      if (!inflight[i].sent) begin
        cands.push_back(i);
      end
    end
    if (cands.size() == 0) begin
      return -1;
    end
    return cands[$urandom_range(0, cands.size() - 1)];
  endfunction

  // retire and credit are taken mid-cycle
  task automatic end_cycle();
    @(negedge clock);
    if (retire.valid && inflight.size() > 0) begin
      void'(inflight.pop_front());
    end
    credits = credits + int'(credit);
    @(posedge clock);
    #1;
  endtask

  task automatic step(input bit try_disp, input int comp_pos);
    flight_t f;
    dispatch = '0;
    complete = '0;
    flush    = '0;
    if (comp_pos >= 0) begin
      f = inflight[comp_pos];
      complete.valid   = 1'b1;
      complete.rob_idx = f.idx;
      f.sent = 1'b1;
      inflight[comp_pos] = f;
    end
    if (try_disp && credits > 0) begin
      dispatch.valid = 1'b1;
      dispatch.t     = random_tag();
      dispatch.t_old = random_tag();
      f.idx  = disp_idx;
      f.sent = 1'b0;
      inflight.push_back(f);
      credits--;
    end
    end_cycle();
  endtask

  // dispatch n instructions, waiting for credits as needed
  task automatic dispatch_n(input int n);
    int done_n;
    int waited;
    done_n = 0;
    waited = 0;
    while (done_n < n && waited < 4 * `ROB_DEPTH) begin
      if (credits > 0) begin
        done_n++;
      end else begin
        waited++;
      end
      step(1'b1, -1);
    end
    if (done_n < n) begin
      $display("no credits came back at %0t, %0d of %0d dispatched", $time, done_n, n);
      stall_errors++;
    end
  endtask

  // squash behind the branch at list position pos, then send
  // completions to the squashed slots
  task automatic mispredict(input int pos);
    rob_idx_t branch;
    rob_idx_t gone[$];
    flight_t  f;
    int       n;
    branch = inflight[pos].idx;
    n = younger_count(branch);
    for (int i = 0; i < n; i++) begin
      f = inflight.pop_back();
      gone.push_back(f.idx);
    end
    complete         = '0;
    dispatch         = '0;
    dispatch.valid   = (credits > 0);
    dispatch.t       = random_tag();
    dispatch.t_old   = random_tag();
    flush.valid      = 1'b1;
    flush.branch_idx = branch;
    squash_exp       = credit_t'(n);
    end_cycle();
    squash_exp = '0;
    dispatch   = '0;
    flush      = '0;
    for (int i = 0; i < gone.size(); i++) begin
      complete.valid   = 1'b1;
      complete.rob_idx = gone[i];
      end_cycle();
    end
  endtask

  // complete what is left and wait for the buffer to empty
  task automatic drain();
    int pos;
    int waited;
    pos = pick_unsent();
    while (pos >= 0) begin
      step(1'b0, pos);
      pos = pick_unsent();
    end
    waited = 0;
    while ((inflight.size() != 0 || credits != `ROB_DEPTH) && waited < 4 * `ROB_DEPTH) begin
      step(1'b0, -1);
      waited++;
    end
    if (inflight.size() != 0 || credits != `ROB_DEPTH) begin
      $display("drain stalled at %0t with %0d in flight and %0d credits",
               $time, inflight.size(), credits);
      stall_errors++;
    end
  endtask

  initial begin
    int comp;
    void'($urandom(32'h36f3));
    reset        = 1'b1;
    dispatch     = '0;
    complete     = '0;
    flush        = '0;
    squash_exp   = '0;
    finished     = 1'b0;
    credits      = `ROB_DEPTH;
    stall_errors = 0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    // quiet after reset, then fill the whole buffer
    repeat (5) step(1'b0, -1);
    dispatch_n(`ROB_DEPTH);
    if (credits != 0) begin
      $display("buffer filled but %0d credits are still held", credits);
      stall_errors++;
    end
    drain();

    // flush across the wrap point with head at 10 and the tail wrapped to 8
    dispatch_n(`ROB_DEPTH);
    for (int i = 0; i < 10; i++) begin
      step(1'b0, position_of(rob_idx_t'(i)));
    end
    dispatch_n(8);
    mispredict(position_of(rob_idx_t'(13)));
    step(1'b1, -1);
    drain();

    for (int op = 0; op < RANDOM_OPS; op++) begin
      if ($urandom_range(0, 99) < 5 && inflight.size() > 0) begin
        mispredict($urandom_range(0, inflight.size() - 1));
      end else begin
        comp = ($urandom_range(0, 99) < 60) ? pick_unsent() : -1;
        step($urandom_range(0, 99) < 65, comp);
      end
    end
    drain();

    finished = 1'b1;
    end_cycle();
    $display("errors: %0d value, %0d other", value_errors, other_errors + stall_errors);
    if (value_errors + other_errors + stall_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry.sv
rtl/rob_retire.sv
rtl/rob_top.sv
dv/rob_checker.sv
dv/rob_tb.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module rob_tb -f all.f

run: compile
	./obj_dir/Vrob_tb > run.log 2>&1; cat run.log
	grep -q "^Testbench passed$$" run.log

clean:
	rm -rf obj_dir run.log
